//--- task_injector.f
+incdir+.
ti_pkg.sv
ti_packet_sender.sv
ti_packet_receiver.sv
ti_inject_ctrl.sv
task_injector.sv
task_injector_sva.sv
tb_task_injector.sv

//--- tb_task_injector.sv
`default_nettype none

`include "ti_macros.svh"

module tb_task_injector;

    localparam logic [7:0] app_id = 8'h5A;
    localparam int timeout_cycles = 4000; // two apps are a few hundred flits

    logic          clk_i;
    logic          rst_ni;
    logic          src_rx_i;
    ti_pkg::flit_t src_data_i;
    logic          src_credit_o;
    logic          noc_tx_o;
    ti_pkg::flit_t noc_data_o;
    logic          noc_credit_i;
    logic          noc_rx_i;
    ti_pkg::flit_t noc_data_i;
    logic          noc_credit_o;

    ti_pkg::flit_t src_q [$];  // words the source still has to deliver
    ti_pkg::flit_t exp_q [$];  // flits expected on the NoC output
    ti_pkg::flit_t in_q  [$];  // packet the mapper is sending
    ti_pkg::flit_t desc_w   [2*`TI_MAX_TASKS];
    ti_pkg::flit_t target_w [`TI_MAX_TASKS];
    ti_pkg::flit_t entry_w  [`TI_MAX_TASKS];
    ti_pkg::flit_t code_w   [`TI_MAX_TASKS][8];
    int            code_sz  [`TI_MAX_TASKS];
    int            app_tasks;
    int            out_cnt = 0;
    int            cycle_cnt = 0;
    logic          src_fire = 1'b0;
    logic          noc_fire = 1'b0;

    task_injector u_dut (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .src_rx_i     (src_rx_i),
        .src_data_i   (src_data_i),
        .src_credit_o (src_credit_o),
        .noc_tx_o     (noc_tx_o),
        .noc_data_o   (noc_data_o),
        .noc_credit_i (noc_credit_i),
        .noc_rx_i     (noc_rx_i),
        .noc_data_i   (noc_data_i),
        .noc_credit_o (noc_credit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_on_failure;
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // reference packet built from the header rules
    function automatic void expected_packet(input bit descriptor, input int t);
        int k;
        if (descriptor) begin
            exp_q.push_back(`TI_MAPPER_ADDR);
            exp_q.push_back(ti_pkg::flit_t'(4 + 2 * app_tasks));
            exp_q.push_back(ti_pkg::MESSAGE_DELIVERY);
            exp_q.push_back(`TI_INJECTOR_ADDR);
            exp_q.push_back(ti_pkg::NEW_APP);
            exp_q.push_back(ti_pkg::flit_t'(app_tasks));
            for (k = 0; k < 2 * app_tasks; k++) begin
                exp_q.push_back(desc_w[k]);
            end
        end else begin
            exp_q.push_back(target_w[t]);
            exp_q.push_back(ti_pkg::flit_t'(4 + code_sz[t]));
            exp_q.push_back(ti_pkg::TASK_ALLOCATION);
            exp_q.push_back(ti_pkg::flit_t'(app_id * 256 + t));
            exp_q.push_back(ti_pkg::flit_t'(code_sz[t]));
            exp_q.push_back(entry_w[t]);
            for (k = 0; k < code_sz[t]; k++) begin
                exp_q.push_back(code_w[t][k]);
            end
        end
    endfunction

    // allocation request from the mapper, extra filler words make it oversize
    function automatic void build_alloc(input ti_pkg::flit_t service, input int extra);
        int k;
        in_q.delete();
        in_q.push_back(`TI_INJECTOR_ADDR);
        in_q.push_back(ti_pkg::flit_t'(4 + 3 + app_tasks + extra));
        in_q.push_back(service);
        in_q.push_back('0);
        in_q.push_back('0);
        in_q.push_back('0);
        in_q.push_back(ti_pkg::APP_ALLOCATION_REQUEST);
        in_q.push_back(ti_pkg::flit_t'(app_id));
        in_q.push_back(ti_pkg::flit_t'(app_tasks));
        for (k = 0; k < app_tasks; k++) begin
            in_q.push_back(target_w[k]);
        end
        for (k = 0; k < extra; k++) begin
            in_q.push_back($urandom);
        end
    endfunction

    function automatic void build_complete;
        in_q.delete();
        in_q.push_back(`TI_INJECTOR_ADDR);
        in_q.push_back(ti_pkg::flit_t'(5));
        in_q.push_back(ti_pkg::MESSAGE_DELIVERY);
        in_q.push_back('0);
        in_q.push_back('0);
        in_q.push_back('0);
        in_q.push_back(ti_pkg::APP_MAPPING_COMPLETE);
    endfunction

    task automatic inject_packet;
        int k;
        k = 0;
        while (k < in_q.size()) begin
            noc_rx_i   = 1'b1;
            noc_data_i = in_q[k];
            @(negedge clk_i);
            if (noc_fire) k++;
        end
        noc_rx_i = 1'b0;
    endtask

    task automatic wait_output_drained;
        while (exp_q.size() != 0) @(negedge clk_i);
    endtask

    task automatic run_app(input int n, input bit with_junk);
        int i;
        int j;
        int out_mark;
        app_tasks = n;
        for (i = 0; i < 2 * n; i++) begin
            desc_w[i] = $urandom;
        end
        for (i = 0; i < n; i++) begin
            target_w[i] = $urandom & 32'h0000_0303; // somewhere on a 4x4 mesh
            code_sz[i]  = $urandom % 6;
            entry_w[i]  = $urandom;
            for (j = 0; j < code_sz[i]; j++) begin
                code_w[i][j] = $urandom;
            end
        end
        expected_packet(1'b1, 0);
        src_q.push_back(ti_pkg::flit_t'(n));
        for (i = 0; i < 2 * n; i++) begin
            src_q.push_back(desc_w[i]);
        end
        for (i = 0; i < n; i++) begin
            src_q.push_back(ti_pkg::flit_t'(code_sz[i]));
            src_q.push_back(entry_w[i]);
            for (j = 0; j < code_sz[i]; j++) begin
                src_q.push_back(code_w[i][j]);
            end
        end
        wait_output_drained();
        if (with_junk) begin
            out_mark = out_cnt;
            build_alloc(ti_pkg::TASK_ALLOCATION, 0); // wrong service
            inject_packet();
            build_alloc(ti_pkg::MESSAGE_DELIVERY, `TI_MAX_PAYLOAD + 1 - 3 - n);
            inject_packet();
            repeat (20) @(negedge clk_i);
            assert (out_cnt == out_mark && noc_tx_o == 1'b0)
            else begin
                $display("Error at %0t: injector sent %0d flits after a discarded packet",
                         $time, out_cnt - out_mark);
                stop_on_failure();
            end
        end
        for (i = 0; i < n; i++) begin
            expected_packet(1'b0, i);
        end
        build_alloc(ti_pkg::MESSAGE_DELIVERY, 0);
        inject_packet();
        wait_output_drained();
        build_complete();
        inject_packet();
    endtask

    always @(posedge clk_i) begin
        src_fire <= src_rx_i && src_credit_o;
        noc_fire <= noc_rx_i && noc_credit_o;
    end

    // source model, holds each word until it is taken
    initial begin : source_driver
        src_rx_i   = 1'b0;
        src_data_i = '0;
        forever begin
            @(negedge clk_i);
            if (src_fire) begin
                src_q.delete(0);
                src_rx_i = 1'b0;
            end
            if (!src_rx_i && src_q.size() > 0 && ($urandom % 4) != 0) begin
                src_rx_i   = 1'b1;
                src_data_i = src_q[0];
            end
        end
    end

    initial begin : credit_driver
        noc_credit_i = 1'b1;
        forever begin
            @(negedge clk_i);
            noc_credit_i = ($urandom % 4) != 0;
        end
    end

    always @(posedge clk_i) begin : compare_flits
        ti_pkg::flit_t want;
        if (rst_ni && noc_tx_o && noc_credit_i) begin
            if (exp_q.size() > 0) want = exp_q[0];
            else want = 'x;
            assert (exp_q.size() > 0 && noc_data_o === want) begin
                want = exp_q.pop_front();
                out_cnt++;
            end else begin
                $display("Error at %0t: NoC flit %0d is %h, expected %h",
                         $time, out_cnt, noc_data_o, want);
                stop_on_failure();
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            stop_on_failure();
        end
    end

    initial begin : stimulus
        int seed_ret;
        seed_ret   = $urandom(32'h0705_7e95);
        rst_ni     = 1'b0;
        noc_rx_i   = 1'b0;
        noc_data_i = '0;
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;
        assert (noc_tx_o == 1'b0 && src_credit_o == 1'b1 && noc_credit_o == 1'b1)
        else begin
            $display("Error at %0t: after reset noc_tx_o=%b src_credit_o=%b noc_credit_o=%b",
                     $time, noc_tx_o, src_credit_o, noc_credit_o);
            stop_on_failure();
        end
        run_app(3, 1'b1);
        run_app(1, 1'b0);
        while (src_credit_o !== 1'b1) @(negedge clk_i); // back in idle
        if (exp_q.size() == 0 && src_q.size() == 0 && out_cnt > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Run ended with source words or expected flits left over");
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

//--- task_injector_sva.sv
`default_nettype none

module task_injector_sva (
    input wire                clk_i,
    input wire                rst_ni,
    input wire                noc_tx_o,
    input wire                noc_credit_i,
    input wire ti_pkg::flit_t noc_data_o,
    input wire                src_credit_o,
    input wire                noc_credit_o
);

    // a stalled flit holds until the credit comes back
    property stall_holds_flit;
        @(posedge clk_i) disable iff (!rst_ni)
            noc_tx_o && !noc_credit_i |=> $stable(noc_data_o);
    endproperty

    property idle_after_reset;
        @(posedge clk_i) $rose(rst_ni) |-> !noc_tx_o && src_credit_o;
    endproperty

    property strobes_known;
        @(posedge clk_i) disable iff (!rst_ni)
            !$isunknown({noc_tx_o, src_credit_o, noc_credit_o});
    endproperty

    a_stall_holds_flit: assert property (stall_holds_flit)
        else $error("noc_data_o changed while a flit was stalled");
    a_idle_after_reset: assert property (idle_after_reset)
        else $error("noc_tx_o or src_credit_o wrong in the first cycle after reset");
    a_strobes_known: assert property (strobes_known)
        else $error("X on a tx or credit output");

endmodule

bind task_injector task_injector_sva u_sva (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .noc_tx_o     (noc_tx_o),
    .noc_credit_i (noc_credit_i),
    .noc_data_o   (noc_data_o),
    .src_credit_o (src_credit_o),
    .noc_credit_o (noc_credit_o)
);

`default_nettype wire

//--- task_injector.sv
`default_nettype none

module task_injector (
    input  wire                clk_i,
    input  wire                rst_ni,
    input  wire                src_rx_i,
    input  wire ti_pkg::flit_t src_data_i,
    output logic               src_credit_o,
    output logic               noc_tx_o,
    output ti_pkg::flit_t      noc_data_o,
    input  wire                noc_credit_i,
    input  wire                noc_rx_i,
    input  wire ti_pkg::flit_t noc_data_i,
    output logic               noc_credit_o
);

    ti_pkg::pkt_header_t send_hdr;
    ti_pkg::flit_t       body_len;
    ti_pkg::flit_t       task_target;
    ti_pkg::rx_event_t   rx_evt;
    logic [3:0]          task_idx;
    logic                send_start;
    logic                send_done;
    logic                ctrl_src_credit;
    logic                send_src_credit;

    ti_inject_ctrl u_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .src_rx_i          (src_rx_i),
        .src_data_i        (src_data_i),
        .src_credit_ctrl_o (ctrl_src_credit),
        .rx_evt_i          (rx_evt),
        .task_target_i     (task_target),
        .task_idx_o        (task_idx),
        .send_start_o      (send_start),
        .send_hdr_o        (send_hdr),
        .body_len_o        (body_len),
        .send_done_i       (send_done)
    );

    ti_packet_sender u_send (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .send_start_i   (send_start),
        .send_hdr_i     (send_hdr),
        .body_len_i     (body_len),
        .noc_credit_i   (noc_credit_i),
        .src_rx_i       (src_rx_i),
        .src_data_i     (src_data_i),
        .noc_tx_o       (noc_tx_o),
        .noc_data_o     (noc_data_o),
        .src_credit_o_o (send_src_credit),
        .send_done_o    (send_done)
    );

    ti_packet_receiver u_recv (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .noc_rx_i      (noc_rx_i),
        .noc_data_i    (noc_data_i),
        .noc_credit_o  (noc_credit_o),
        .task_idx_i    (task_idx),
        .task_target_o (task_target),
        .rx_evt_o      (rx_evt)
    );

    assign src_credit_o = ctrl_src_credit | send_src_credit; // phases never overlap

endmodule

`default_nettype wire

//--- ti_inject_ctrl.sv
`default_nettype none

`include "ti_macros.svh"

module ti_inject_ctrl (
    input  wire                      clk_i,
    input  wire                      rst_ni,
    input  wire                      src_rx_i,
    input  wire ti_pkg::flit_t       src_data_i,
    output logic                     src_credit_ctrl_o,
    input  wire ti_pkg::rx_event_t   rx_evt_i,
    input  wire ti_pkg::flit_t       task_target_i,
    output logic [3:0]               task_idx_o,
    output logic                     send_start_o,
    output ti_pkg::pkt_header_t      send_hdr_o,
    output ti_pkg::flit_t            body_len_o,
    input  wire                      send_done_i
);

    ti_pkg::inject_state_e state_q;
    logic [3:0] task_cnt_q;
    logic [7:0] app_id_q;
    logic [3:0] cnt_in;
    logic src_xfer;

    assign src_credit_ctrl_o = state_q inside {ti_pkg::IJ_IDLE, ti_pkg::IJ_CODE_SIZE,
                                               ti_pkg::IJ_ENTRY};
    assign src_xfer = src_rx_i && src_credit_ctrl_o;
    assign cnt_in   = src_data_i[3:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ti_pkg::IJ_IDLE;
            task_cnt_q   <= '0;
            app_id_q     <= '0;
            task_idx_o   <= '0;
            send_start_o <= 1'b0;
        end else begin
            send_start_o <= 1'b0;
            case (state_q)
                ti_pkg::IJ_IDLE: begin
                    if (src_xfer) begin
                        task_cnt_q   <= cnt_in;
                        send_start_o <= 1'b1; // descriptor header built below
                        state_q      <= ti_pkg::IJ_DESCRIPTOR;
                    end
                end
                ti_pkg::IJ_DESCRIPTOR: begin
                    if (send_done_i) state_q <= ti_pkg::IJ_MAP;
                end
                ti_pkg::IJ_MAP: begin
                    if (rx_evt_i.alloc) begin
                        app_id_q   <= rx_evt_i.app_id;
                        task_cnt_q <= (rx_evt_i.task_cnt > `TI_MAX_TASKS)
                                      ? 4'(`TI_MAX_TASKS) : rx_evt_i.task_cnt;
                        task_idx_o <= '0;
                        state_q    <= (rx_evt_i.task_cnt == '0)
                                      ? ti_pkg::IJ_WAIT_COMPLETE : ti_pkg::IJ_CODE_SIZE;
                    end
                end
                ti_pkg::IJ_CODE_SIZE: begin
                    if (src_xfer) state_q <= ti_pkg::IJ_ENTRY;
                end
                ti_pkg::IJ_ENTRY: begin
                    if (src_xfer) begin
                        send_start_o <= 1'b1;
                        state_q      <= ti_pkg::IJ_SEND_TASK;
                    end
                end
                ti_pkg::IJ_SEND_TASK: begin
                    if (send_done_i) state_q <= ti_pkg::IJ_NEXT_TASK;
                end
                ti_pkg::IJ_NEXT_TASK: begin
                    if (task_idx_o == task_cnt_q - 1'b1) begin
                        state_q <= ti_pkg::IJ_WAIT_COMPLETE;
                    end else begin
                        task_idx_o <= task_idx_o + 1'b1;
                        state_q    <= ti_pkg::IJ_CODE_SIZE;
                    end
                end
                default: begin
                    if (rx_evt_i.done) state_q <= ti_pkg::IJ_IDLE;
                end
            endcase
        end
    end

    // header words, stable while the sender is busy
    always_ff @(posedge clk_i) begin
        if (state_q == ti_pkg::IJ_IDLE && src_xfer) begin
            send_hdr_o.target    <= `TI_MAPPER_ADDR;
            send_hdr_o.size      <= ti_pkg::flit_t'(`TI_HEADER_LEN - 2)
                                    + ti_pkg::flit_t'({cnt_in, 1'b0});
            send_hdr_o.service   <= ti_pkg::MESSAGE_DELIVERY;
            send_hdr_o.task_id   <= `TI_INJECTOR_ADDR;
            send_hdr_o.code_size <= ti_pkg::NEW_APP;
            send_hdr_o.entry     <= ti_pkg::flit_t'(cnt_in);
            body_len_o           <= ti_pkg::flit_t'({cnt_in, 1'b0}); // two words per task
        end
        if (state_q == ti_pkg::IJ_CODE_SIZE && src_xfer) begin
            send_hdr_o.target    <= task_target_i;
            send_hdr_o.size      <= src_data_i + ti_pkg::flit_t'(`TI_HEADER_LEN - 2);
            send_hdr_o.service   <= ti_pkg::TASK_ALLOCATION;
            send_hdr_o.task_id   <= ti_pkg::flit_t'({app_id_q, 4'd0, task_idx_o});
            send_hdr_o.code_size <= src_data_i;
            body_len_o           <= src_data_i;
        end
        if (state_q == ti_pkg::IJ_ENTRY && src_xfer) begin
            send_hdr_o.entry <= src_data_i;
        end
    end

endmodule

`default_nettype wire

//--- ti_packet_receiver.sv
`default_nettype none

`include "ti_macros.svh"

module ti_packet_receiver (
    input  wire                    clk_i,
    input  wire                    rst_ni,
    input  wire                    noc_rx_i,
    input  wire ti_pkg::flit_t     noc_data_i,
    output logic                   noc_credit_o,
    input  wire [3:0]              task_idx_i,
    output ti_pkg::flit_t          task_target_o,
    output ti_pkg::rx_event_t      rx_evt_o
);

    localparam int pw = $clog2(`TI_MAX_PAYLOAD);

    ti_pkg::recv_state_e state_q, state_d;
    logic [$clog2(`TI_HEADER_LEN)-1:0] hdr_idx_q;
    ti_pkg::flit_t size_q;
    ti_pkg::flit_t svc_q;
    ti_pkg::flit_t pay_cnt_q;
    ti_pkg::flit_t pay_len;
    ti_pkg::flit_t pay_q [`TI_MAX_PAYLOAD];
    logic [pw-1:0] tgt_idx;
    logic rx_xfer;
    logic hdr_last;
    logic pay_empty;
    logic pay_last;
    logic is_dlvr;

    assign noc_credit_o = state_q != ti_pkg::RCV_DECODE;
    assign rx_xfer      = noc_rx_i && noc_credit_o;
    assign hdr_last     = hdr_idx_q == `TI_HEADER_LEN - 1;
    assign pay_len      = size_q - ti_pkg::flit_t'(`TI_HEADER_LEN - 2);
    assign pay_empty    = size_q <= `TI_HEADER_LEN - 2;
    assign pay_last     = pay_cnt_q == pay_len - 1'b1;

    // oversize packets are routed to drop once the whole header is in
    always_comb begin
        state_d = state_q;
        case (state_q)
            ti_pkg::RCV_HEADER: begin
                if (rx_xfer && hdr_last) begin
                    if (pay_empty) begin
                        state_d = ti_pkg::RCV_DECODE;
                    end else if (pay_len > `TI_MAX_PAYLOAD) begin
                        state_d = ti_pkg::RCV_DROP;
                    end else begin
                        state_d = ti_pkg::RCV_PAYLOAD;
                    end
                end
            end
            ti_pkg::RCV_PAYLOAD: begin
                if (rx_xfer && pay_last) state_d = ti_pkg::RCV_DECODE;
            end
            ti_pkg::RCV_DROP: begin
                if (rx_xfer && pay_last) state_d = ti_pkg::RCV_HEADER; // no event
            end
            default: state_d = ti_pkg::RCV_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ti_pkg::RCV_HEADER;
            hdr_idx_q <= '0;
            pay_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ti_pkg::RCV_HEADER) begin
                pay_cnt_q <= '0;
                if (rx_xfer) hdr_idx_q <= hdr_last ? '0 : hdr_idx_q + 1'b1;
            end else if (rx_xfer) begin
                pay_cnt_q <= pay_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ti_pkg::RCV_HEADER && rx_xfer) begin
            if (hdr_idx_q == 1) size_q <= noc_data_i;
            if (hdr_idx_q == 2) svc_q <= noc_data_i;
        end
        if (state_q == ti_pkg::RCV_PAYLOAD && rx_xfer) begin
            pay_q[pay_cnt_q[pw-1:0]] <= noc_data_i;
        end
    end

    // targets follow opcode, app id and task count
    assign tgt_idx       = pw'(task_idx_i) + pw'(3);
    assign task_target_o = pay_q[tgt_idx];

    always_comb begin
        is_dlvr = state_q == ti_pkg::RCV_DECODE && svc_q == ti_pkg::MESSAGE_DELIVERY
                  && pay_cnt_q != '0;
        rx_evt_o.alloc    = is_dlvr && pay_q[0] == ti_pkg::APP_ALLOCATION_REQUEST
                            && pay_cnt_q > 2;
        rx_evt_o.done     = is_dlvr && pay_q[0] == ti_pkg::APP_MAPPING_COMPLETE;
        rx_evt_o.app_id   = pay_q[1][7:0];
        rx_evt_o.task_cnt = pay_q[2][3:0];
    end

endmodule

`default_nettype wire

//--- ti_packet_sender.sv
`default_nettype none

`include "ti_macros.svh"

module ti_packet_sender (
    input  wire                      clk_i,
    input  wire                      rst_ni,
    input  wire                      send_start_i,
    input  wire ti_pkg::pkt_header_t send_hdr_i,
    input  wire ti_pkg::flit_t       body_len_i,
    input  wire                      noc_credit_i,
    input  wire                      src_rx_i,
    input  wire ti_pkg::flit_t       src_data_i,
    output logic                     noc_tx_o,
    output ti_pkg::flit_t            noc_data_o,
    output logic                     src_credit_o_o,
    output logic                     send_done_o
);

    ti_pkg::send_state_e state_q, state_d;
    logic [$clog2(`TI_HEADER_LEN)-1:0] hdr_idx_q;
    ti_pkg::flit_t body_cnt_q;
    ti_pkg::flit_t [`TI_HEADER_LEN-1:0] hdr_flits;
    logic hdr_last;
    logic body_xfer;
    logic body_last;

    assign hdr_flits = send_hdr_i; // target sits in the top flit
    assign hdr_last  = hdr_idx_q == `TI_HEADER_LEN - 1;
    assign body_xfer = state_q == ti_pkg::SND_BODY && src_rx_i && noc_credit_i;
    assign body_last = body_cnt_q == body_len_i - 1'b1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ti_pkg::SND_IDLE: begin
                if (send_start_i) state_d = ti_pkg::SND_HEADER;
            end
            ti_pkg::SND_HEADER: begin
                if (noc_credit_i && hdr_last) begin
                    state_d = (body_len_i == '0) ? ti_pkg::SND_DONE : ti_pkg::SND_BODY;
                end
            end
            ti_pkg::SND_BODY: begin
                if (body_xfer && body_last) state_d = ti_pkg::SND_DONE;
            end
            default: state_d = ti_pkg::SND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= ti_pkg::SND_IDLE;
            hdr_idx_q  <= '0;
            body_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ti_pkg::SND_IDLE) begin
                hdr_idx_q  <= '0;
                body_cnt_q <= '0;
            end else begin
                if (state_q == ti_pkg::SND_HEADER && noc_credit_i) begin
                    hdr_idx_q <= hdr_idx_q + 1'b1;
                end
                if (body_xfer) body_cnt_q <= body_cnt_q + 1'b1;
            end
        end
    end

    // body phase is a straight pass-through of the source handshake
    always_comb begin
        noc_tx_o       = 1'b0;
        noc_data_o     = src_data_i;
        src_credit_o_o = 1'b0;
        case (state_q)
            ti_pkg::SND_HEADER: begin
                noc_tx_o   = 1'b1;
                noc_data_o = hdr_flits[`TI_HEADER_LEN - 1 - hdr_idx_q];
            end
            ti_pkg::SND_BODY: begin
                noc_tx_o       = src_rx_i;
                src_credit_o_o = noc_credit_i;
            end
            default: ;
        endcase
    end

    assign send_done_o = state_q == ti_pkg::SND_DONE;

endmodule

`default_nettype wire

//--- ti_pkg.sv
`default_nettype none

`include "ti_macros.svh"

package ti_pkg;

    typedef logic [`TI_FLIT_W-1:0] flit_t;

    typedef enum logic [`TI_FLIT_W-1:0] {
        MESSAGE_DELIVERY = 32'h0000_0010,
        TASK_ALLOCATION  = 32'h0000_0040
    } service_e;

    // first payload word of a delivery packet
    typedef enum logic [`TI_FLIT_W-1:0] {
        NEW_APP                = 32'h0000_0100,
        APP_ALLOCATION_REQUEST = 32'h0000_0101,
        APP_MAPPING_COMPLETE   = 32'h0000_0102
    } opcode_e;

    // target is the first flit on the wire
    typedef struct packed {
        flit_t    target;
        flit_t    size;      // flits after this one
        service_e service;
        flit_t    task_id;
        flit_t    code_size; // opcode for the descriptor
        flit_t    entry;     // task count for the descriptor
    } pkt_header_t;

    typedef struct packed {
        logic       alloc;
        logic       done;
        logic [7:0] app_id;
        logic [3:0] task_cnt;
    } rx_event_t;

    typedef enum logic [2:0] {
        IJ_IDLE,
        IJ_DESCRIPTOR,
        IJ_MAP,
        IJ_CODE_SIZE,
        IJ_ENTRY,
        IJ_SEND_TASK,
        IJ_NEXT_TASK,
        IJ_WAIT_COMPLETE
    } inject_state_e;

    typedef enum logic [1:0] {
        SND_IDLE,
        SND_HEADER,
        SND_BODY,
        SND_DONE
    } send_state_e;

    typedef enum logic [1:0] {
        RCV_HEADER,
        RCV_PAYLOAD,
        RCV_DROP,
        RCV_DECODE
    } recv_state_e;

endpackage

`default_nettype wire

//--- ti_macros.svh
`ifndef TI_MACROS_SVH
`define TI_MACROS_SVH

// flit and header geometry
`define TI_FLIT_W        32
`define TI_HEADER_LEN    6

// receive buffer depth in payload flits
`define TI_MAX_PAYLOAD   16

// largest application the injector will sequence
`define TI_MAX_TASKS     8

// node addresses on the mesh, x in [15:8], y in [7:0]
`define TI_MAPPER_ADDR   32'h0000_0000
`define TI_INJECTOR_ADDR 32'h0000_0202

`endif
